//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = tb_adc_uart
FILELIST = files.f
OBJDIR   = obj_dir

SOURCES  = $(shell grep -v '^+' $(FILELIST))
BIN      = $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJDIR)

//--- adc_pkg.sv
// ADC link shared definitions
package adc_pkg;

    localparam int NUM_CH     = 4;
    localparam int SAMPLE_W   = 10;
    localparam int SCLK_HALF  = 4;                // clk cycles per sclk half period.
    localparam int FRAME_BITS = 16;
    localparam int GAP_BITS   = 2;                // cs stays high this many sclk periods.
    localparam int DATA_FIRST = 3;
    localparam int DATA_LAST  = DATA_FIRST + SAMPLE_W - 1;
    localparam int BAUD_DIV   = 16;
    localparam int UART_BITS  = 10;               // Start, eight data bits and stop.

    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [7:0]          byte_t;
    typedef logic [3:0]          byte_sel_t;

    // Counter widths for the clock enables and frame position.
    typedef logic [$clog2(SCLK_HALF)-1:0]           sclk_cnt_t;
    typedef logic [$clog2(FRAME_BITS+GAP_BITS)-1:0] frame_cnt_t;
    typedef logic [$clog2(BAUD_DIV)-1:0]            baud_cnt_t;
    typedef logic [3:0]                             uart_bit_t;

    localparam byte_t     CMD_ALL  = 8'h10;
    localparam byte_t     ERR_CODE = 8'hEE;
    localparam byte_sel_t SEL_ERR  = 4'd8;        // Byte select that returns the error code.

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_SNAP,
        CTRL_SEND,
        CTRL_WAIT
    } ctrl_state_t;

endpackage

//--- adc_uart_chk.sv
// Link protocol assertions
`timescale 1ns/1ps

module adc_uart_chk (
    input logic clk,
    input logic reset_b,
    input logic cs,
    input logic sclk,
    input logic rx_valid,
    input logic hold,
    input logic tx_start,
    input logic tx_ready
);

    // The transmitter takes the byte and drops tx_ready on the next cycle.
    start_when_ready: assert property (
        @(posedge clk) disable iff (!reset_b) tx_start |-> tx_ready ##1 !tx_ready
    ) else $error("tx_start came without tx_ready, or tx_ready did not drop after it.");

    // The serial clock only runs inside the cs window.
    sclk_idle_in_gap: assert property (
        @(posedge clk) disable iff (!reset_b) cs |-> !sclk
    ) else $error("sclk was high while cs was high.");

    hold_single_pulse: assert property (
        @(posedge clk) disable iff (!reset_b) hold |-> $past(rx_valid) ##1 !hold
    ) else $error("hold was not a single pulse following a received command.");

endmodule

bind adc_uart_top adc_uart_chk chk0 (
    .clk      (clk),
    .reset_b  (reset_b),
    .cs       (cs),
    .sclk     (sclk),
    .rx_valid (rx_valid),
    .hold     (hold),
    .tx_start (tx_start),
    .tx_ready (tx_ready)
);

//--- adc_uart_top.sv
// ADC to UART link top level
`timescale 1ns/1ps

module adc_uart_top (
    input  logic                       clk,
    input  logic                       reset_b,
    input  logic [adc_pkg::NUM_CH-1:0] adc_data,
    output logic                       cs,
    output logic                       sclk,
    input  logic                       rxd,
    output logic                       txd
);

    adc_pkg::sample_t [adc_pkg::NUM_CH-1:0] ch_sample;
    logic                                   sample_valid;
    adc_pkg::byte_t                         rx_byte;
    logic                                   rx_valid;
    logic                                   hold;
    adc_pkg::byte_sel_t                     byte_sel;
    logic                                   tx_start;
    adc_pkg::byte_t                         tx_byte;
    logic                                   tx_ready;

    spi_adc_rx spi0 (
        .clk          (clk),
        .reset_b      (reset_b),
        .adc_data     (adc_data),
        .cs           (cs),
        .sclk         (sclk),
        .ch_sample    (ch_sample),
        .sample_valid (sample_valid)
    );

    sample_bank bank0 (
        .clk          (clk),
        .reset_b      (reset_b),
        .ch_sample    (ch_sample),
        .sample_valid (sample_valid),
        .hold         (hold),
        .byte_sel     (byte_sel),
        .tx_byte      (tx_byte)
    );

    uart_rx rx0 (
        .clk      (clk),
        .reset_b  (reset_b),
        .rxd      (rxd),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    uart_tx tx0 (
        .clk      (clk),
        .reset_b  (reset_b),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .txd      (txd),
        .tx_ready (tx_ready)
    );

    link_ctrl ctrl0 (
        .clk      (clk),
        .reset_b  (reset_b),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .tx_ready (tx_ready),
        .hold     (hold),
        .byte_sel (byte_sel),
        .tx_start (tx_start)
    );

endmodule

//--- files.f
adc_pkg.sv
spi_adc_rx.sv
sample_bank.sv
uart_rx.sv
uart_tx.sv
link_ctrl.sv
adc_uart_top.sv
adc_uart_chk.sv
tb_adc_uart.sv

//--- link_ctrl.sv
// Command decode and reply sequencer
`timescale 1ns/1ps

module link_ctrl (
    input  logic               clk,
    input  logic               reset_b,
    input  adc_pkg::byte_t     rx_byte,
    input  logic               rx_valid,
    input  logic               tx_ready,
    output logic               hold,
    output adc_pkg::byte_sel_t byte_sel,
    output logic               tx_start
);

    adc_pkg::ctrl_state_t state;
    adc_pkg::byte_sel_t   sel_q;
    adc_pkg::byte_sel_t   last_q;
    logic [1:0]           ch_idx;
    logic                 is_chan;

    assign ch_idx   = rx_byte[1:0] - 2'd1;      // Commands 1 to 4 map to channel 0 to 3.
    assign is_chan  = (rx_byte != '0) && (rx_byte <= adc_pkg::byte_t'(adc_pkg::NUM_CH));
    assign hold     = (state == adc_pkg::CTRL_SNAP);
    assign tx_start = (state == adc_pkg::CTRL_SEND) && tx_ready;
    assign byte_sel = sel_q;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state  <= adc_pkg::CTRL_IDLE;
            sel_q  <= '0;
            last_q <= '0;
        end else begin
            case (state)
                adc_pkg::CTRL_IDLE: begin
                    if (rx_valid) begin
                        state <= adc_pkg::CTRL_SNAP;
                        if (is_chan) begin
                            sel_q  <= {1'b0, ch_idx, 1'b0};
                            last_q <= {1'b0, ch_idx, 1'b1};
                        end else if (rx_byte == adc_pkg::CMD_ALL) begin
                            sel_q  <= '0;
                            last_q <= adc_pkg::byte_sel_t'(2 * adc_pkg::NUM_CH - 1);
                        end else begin
                            sel_q  <= adc_pkg::SEL_ERR;
                            last_q <= adc_pkg::SEL_ERR;
                        end
                    end
                end
                adc_pkg::CTRL_SNAP: begin
                    state <= adc_pkg::CTRL_SEND;
                end
                adc_pkg::CTRL_SEND: begin
                    if (tx_ready) begin
                        state <= adc_pkg::CTRL_WAIT;    // tx_start fires this cycle.
                    end
                end
                adc_pkg::CTRL_WAIT: begin
                    if (!tx_ready) begin
                        if (sel_q == last_q) begin
                            state <= adc_pkg::CTRL_IDLE;
                        end else begin
                            sel_q <= sel_q + 1'b1;
                            state <= adc_pkg::CTRL_SEND;
                        end
                    end
                end
                default: begin
                    state <= adc_pkg::CTRL_IDLE;
                end
            endcase
        end
    end

endmodule

//--- sample_bank.sv
// Sample storage and reply byte select
`timescale 1ns/1ps

module sample_bank (
    input  logic                                   clk,
    input  logic                                   reset_b,
    input  adc_pkg::sample_t [adc_pkg::NUM_CH-1:0] ch_sample,
    input  logic                                   sample_valid,
    input  logic                                   hold,
    input  adc_pkg::byte_sel_t                     byte_sel,
    output adc_pkg::byte_t                         tx_byte
);

    adc_pkg::sample_t [adc_pkg::NUM_CH-1:0] live_q;
    adc_pkg::sample_t [adc_pkg::NUM_CH-1:0] snap_q;
    adc_pkg::sample_t                       sel_sample;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            live_q <= '0;
            snap_q <= '0;
        end else begin
            if (sample_valid) begin
                live_q <= ch_sample;
            end
            if (hold) begin
                snap_q <= live_q;               // One reply reads one conversion set.
            end
        end
    end

    assign sel_sample = snap_q[byte_sel[2:1]];

    always_comb begin
        if (byte_sel[3]) begin
            tx_byte = adc_pkg::ERR_CODE;
        end else if (byte_sel[0]) begin
            tx_byte = sel_sample[7:0];
        end else begin
            tx_byte = adc_pkg::byte_t'(sel_sample[adc_pkg::SAMPLE_W-1:8]);
        end
    end

endmodule

//--- spi_adc_rx.sv
// ADC serial front end
`timescale 1ns/1ps

module spi_adc_rx (
    input  logic                                   clk,
    input  logic                                   reset_b,
    input  logic [adc_pkg::NUM_CH-1:0]             adc_data,
    output logic                                   cs,
    output logic                                   sclk,
    output adc_pkg::sample_t [adc_pkg::NUM_CH-1:0] ch_sample,
    output logic                                   sample_valid
);

    adc_pkg::sclk_cnt_t                     half_cnt;
    logic                                   high_half;
    adc_pkg::frame_cnt_t                    bit_cnt;
    adc_pkg::sample_t [adc_pkg::NUM_CH-1:0] shift_q;
    logic                                   half_tick;
    logic                                   in_frame;
    logic                                   in_data;

    assign half_tick = (half_cnt == adc_pkg::sclk_cnt_t'(adc_pkg::SCLK_HALF - 1));
    assign in_frame  = (bit_cnt < adc_pkg::frame_cnt_t'(adc_pkg::FRAME_BITS));
    assign in_data   = (bit_cnt >= adc_pkg::frame_cnt_t'(adc_pkg::DATA_FIRST)) &&
                       (bit_cnt <= adc_pkg::frame_cnt_t'(adc_pkg::DATA_LAST));

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            half_cnt     <= '0;
            high_half    <= 1'b0;
            bit_cnt      <= adc_pkg::frame_cnt_t'(adc_pkg::FRAME_BITS); // Start in the gap.
            cs           <= 1'b1;
            sclk         <= 1'b0;
            sample_valid <= 1'b0;
            ch_sample    <= '0;
        end else begin
            sample_valid <= 1'b0;
            if (half_tick) begin
                half_cnt  <= '0;
                high_half <= !high_half;
                if (!high_half) begin
                    sclk <= in_frame;               // Rising edge only inside the cs window.
                end else begin
                    sclk <= 1'b0;
                    if (bit_cnt == adc_pkg::frame_cnt_t'(adc_pkg::FRAME_BITS +
                                                         adc_pkg::GAP_BITS - 1)) begin
                        bit_cnt <= '0;
                        cs      <= 1'b0;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == adc_pkg::frame_cnt_t'(adc_pkg::FRAME_BITS - 1)) begin
                            cs           <= 1'b1;
                            sample_valid <= 1'b1;
                            ch_sample    <= shift_q;
                        end
                    end
                end
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

    // The data lines are taken on the clk edge that raises sclk.
    always_ff @(posedge clk) begin
        if (half_tick && !high_half && in_data) begin
            for (int i = 0; i < adc_pkg::NUM_CH; i++) begin
                shift_q[i] <= {shift_q[i][adc_pkg::SAMPLE_W-2:0], adc_data[i]};
            end
        end
    end

endmodule

//--- tb_adc_uart.sv
// ADC link testbench
`timescale 1ns/1ps

module tb_adc_uart;

    logic                       clk;
    logic                       reset_b;
    logic [adc_pkg::NUM_CH-1:0] adc_data;
    logic                       cs;
    logic                       sclk;
    logic                       rxd;
    logic                       txd;

    adc_pkg::sample_t adc_val [adc_pkg::NUM_CH];   // Value each ADC model converts next.
    adc_pkg::byte_t   rx_q [$];                    // Bytes decoded from txd.

    adc_uart_top dut0 (
        .clk      (clk),
        .reset_b  (reset_b),
        .adc_data (adc_data),
        .cs       (cs),
        .sclk     (sclk),
        .rxd      (rxd),
        .txd      (txd)
    );

    always #4 clk = !clk;

    function automatic logic frame_bit(adc_pkg::sample_t v, int k);
        if (k < adc_pkg::DATA_FIRST || k > adc_pkg::DATA_LAST) begin
            return 1'b0;
        end
        return v[adc_pkg::DATA_LAST - k];          // MSB goes out first.
    endfunction

    function automatic adc_pkg::byte_t high_byte(adc_pkg::sample_t v);
        return {6'b0, v[9:8]};
    endfunction

    function automatic adc_pkg::byte_t low_byte(adc_pkg::sample_t v);
        return v[7:0];
    endfunction

    task automatic stop_on_error();
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("FAILED at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    // Host side of the UART, one start, eight data and one stop bit.
    task automatic send_byte(input adc_pkg::byte_t b);
        logic [adc_pkg::UART_BITS-1:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < adc_pkg::UART_BITS; i++) begin
            @(posedge clk);
            rxd <= frame[i];
            repeat (adc_pkg::BAUD_DIV - 1) @(posedge clk);
        end
    endtask

    // Waits for n bytes, then for 20 quiet bit times.
    task automatic collect_reply(input int n);
        int waited;
        waited = 0;
        while (rx_q.size() < n && waited < n * adc_pkg::UART_BITS * adc_pkg::BAUD_DIV + 400) begin
            @(posedge clk);
            waited++;
        end
        assert (rx_q.size() >= n) else begin
            $display("Reply timed out with %0d of %0d bytes received.", rx_q.size(), n);
            stop_on_error();
        end
        repeat (20 * adc_pkg::BAUD_DIV) @(posedge clk);
        check_value("reply byte count", rx_q.size(), n);
    endtask

    task automatic wait_frames();
        repeat (2) @(negedge cs);                  // Second frame surely carries the new values.
        @(posedge cs);
        repeat (2) @(posedge clk);
    endtask

    task automatic set_random_values();
        @(posedge clk);
        for (int c = 0; c < adc_pkg::NUM_CH; c++) begin
            adc_val[c] <= adc_val[c] ^ adc_pkg::sample_t'(($urandom % 1023) + 1);
        end
    endtask

    task automatic read_channel(input int ch);
        rx_q.delete();
        send_byte(adc_pkg::byte_t'(ch + 1));
        collect_reply(2);
        check_value($sformatf("ch%0d high byte", ch + 1), int'(rx_q[0]),
                    int'(high_byte(adc_val[ch])));
        check_value($sformatf("ch%0d low byte", ch + 1), int'(rx_q[1]),
                    int'(low_byte(adc_val[ch])));
    endtask

    task automatic verify_reset_state();
        int   cycles;
        logic cs_fell;
        logic sclk_rose;
        @(negedge clk);
        check_value("cs", int'(cs), 1);
        check_value("sclk", int'(sclk), 0);
        check_value("txd", int'(txd), 1);
        cs_fell   = 1'b0;
        sclk_rose = 1'b0;
        cycles    = 0;
        while (!(cs_fell && sclk_rose) && cycles < 300) begin
            @(negedge clk);
            cs_fell   = cs_fell || !cs;
            sclk_rose = sclk_rose || (cs_fell && sclk);
            cycles++;
        end
        assert (cs_fell && sclk_rose) else begin
            $display("ADC bus did not start a frame within 300 cycles of reset.");
            stop_on_error();
        end
    endtask

    task automatic read_each_channel();
        for (int ch = 0; ch < adc_pkg::NUM_CH; ch++) begin
            set_random_values();
            wait_frames();
            read_channel(ch);
        end
    endtask

    task automatic read_all_channels();
        rx_q.delete();
        send_byte(adc_pkg::CMD_ALL);
        collect_reply(2 * adc_pkg::NUM_CH);
        for (int ch = 0; ch < adc_pkg::NUM_CH; ch++) begin
            check_value($sformatf("all ch%0d high byte", ch + 1), int'(rx_q[2 * ch]),
                        int'(high_byte(adc_val[ch])));
            check_value($sformatf("all ch%0d low byte", ch + 1), int'(rx_q[2 * ch + 1]),
                        int'(low_byte(adc_val[ch])));
        end
    endtask

    task automatic reject_unknown_cmd();
        adc_pkg::byte_t cmd;
        cmd = adc_pkg::byte_t'($urandom);
        while ((cmd >= 8'd1 && cmd <= 8'd4) || cmd == adc_pkg::CMD_ALL) begin
            cmd = adc_pkg::byte_t'($urandom);
        end
        rx_q.delete();
        send_byte(cmd);
        collect_reply(1);
        check_value("error reply", int'(rx_q[0]), int'(adc_pkg::ERR_CODE));
    endtask

    task automatic drop_busy_cmd();
        int ch;
        ch = int'($urandom % 4);
        rx_q.delete();
        send_byte(adc_pkg::byte_t'(ch + 1));
        send_byte(adc_pkg::CMD_ALL);               // Arrives while the first reply is going out.
        collect_reply(2);
        check_value("busy high byte", int'(rx_q[0]), int'(high_byte(adc_val[ch])));
        check_value("busy low byte", int'(rx_q[1]), int'(low_byte(adc_val[ch])));
    endtask

    task automatic follow_new_samples();
        set_random_values();
        wait_frames();
        read_all_channels();
    endtask

    // ADC models, all four share cs and sclk.
    initial begin : adc_model
        adc_pkg::sample_t frame_val [adc_pkg::NUM_CH];
        adc_data = '0;
        forever begin
            @(negedge cs);
            frame_val = adc_val;
            adc_data <= '0;
            for (int k = 1; k < adc_pkg::FRAME_BITS; k++) begin
                @(negedge sclk);
                for (int c = 0; c < adc_pkg::NUM_CH; c++) begin
                    adc_data[c] <= frame_bit(frame_val[c], k);
                end
            end
        end
    end

    initial begin : txd_monitor
        adc_pkg::byte_t b;
        forever begin
            @(negedge clk);
            if (reset_b && !txd) begin
                repeat (adc_pkg::BAUD_DIV / 2) @(negedge clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (adc_pkg::BAUD_DIV) @(negedge clk);
                    b[i] = txd;
                end
                repeat (adc_pkg::BAUD_DIV) @(negedge clk);
                assert (txd) else begin
                    $display("FAILED at %0t: txd stop bit = 0, expected 1", $time);
                    stop_on_error();
                end
                rx_q.push_back(b);
            end
        end
    end

    initial begin : watchdog
        int limit_cycles;
        limit_cycles = 36 * adc_pkg::UART_BITS * adc_pkg::BAUD_DIV + 10000; // 36 bytes in all.
        repeat (limit_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the tests did not finish.", limit_cycles);
        stop_on_error();
    end

    initial begin
        void'($urandom(64455));
        clk     = 1'b0;
        reset_b = 1'b0;
        rxd     = 1'b1;
        for (int c = 0; c < adc_pkg::NUM_CH; c++) begin
            adc_val[c] = '0;
        end
        repeat (5) @(posedge clk);
        reset_b <= 1'b1;
        verify_reset_state();
        read_each_channel();
        read_all_channels();
        reject_unknown_cmd();
        drop_busy_cmd();
        follow_new_samples();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- uart_rx.sv
// UART 8N1 receiver
`timescale 1ns/1ps

module uart_rx (
    input  logic           clk,
    input  logic           reset_b,
    input  logic           rxd,
    output adc_pkg::byte_t rx_byte,
    output logic           rx_valid
);

    logic                rxd_meta;
    logic                rxd_sync;
    logic                rxd_prev;
    logic                busy;
    logic                bit_tick;
    adc_pkg::baud_cnt_t  baud_cnt;
    adc_pkg::uart_bit_t  bit_idx;
    adc_pkg::byte_t      data_q;

    assign bit_tick = busy && (baud_cnt == '0);
    assign rx_byte  = data_q;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!busy) begin
                if (rxd_prev && !rxd_sync) begin
                    busy     <= 1'b1;
                    baud_cnt <= adc_pkg::baud_cnt_t'(adc_pkg::BAUD_DIV / 2 - 1); // Half a bit.
                    bit_idx  <= '0;
                end
            end else if (!bit_tick) begin
                baud_cnt <= baud_cnt - 1'b1;
            end else begin
                baud_cnt <= adc_pkg::baud_cnt_t'(adc_pkg::BAUD_DIV - 1);
                bit_idx  <= bit_idx + 1'b1;
                if ((bit_idx == '0) && rxd_sync) begin
                    busy <= 1'b0;               // Glitch, not a start bit.
                end else if (bit_idx == adc_pkg::uart_bit_t'(adc_pkg::UART_BITS - 1)) begin
                    busy     <= 1'b0;
                    rx_valid <= rxd_sync;       // Framing error drops the byte.
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bit_tick && (bit_idx != '0) &&
            (bit_idx != adc_pkg::uart_bit_t'(adc_pkg::UART_BITS - 1))) begin
            data_q <= {rxd_sync, data_q[7:1]};
        end
    end

endmodule

//--- uart_tx.sv
// UART 8N1 transmitter
`timescale 1ns/1ps

module uart_tx (
    input  logic           clk,
    input  logic           reset_b,
    input  logic           tx_start,
    input  adc_pkg::byte_t tx_byte,
    output logic           txd,
    output logic           tx_ready
);

    logic [adc_pkg::UART_BITS-1:0] frame_q;
    logic                          busy;
    adc_pkg::baud_cnt_t            baud_cnt;
    adc_pkg::uart_bit_t            bits_left;

    assign txd      = frame_q[0];
    assign tx_ready = !busy;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            frame_q   <= '1;                    // Line idles high.
            busy      <= 1'b0;
            baud_cnt  <= '0;
            bits_left <= '0;
        end else begin
            if (!busy) begin
                if (tx_start) begin
                    frame_q   <= {1'b1, tx_byte, 1'b0};
                    busy      <= 1'b1;
                    baud_cnt  <= adc_pkg::baud_cnt_t'(adc_pkg::BAUD_DIV - 1);
                    bits_left <= adc_pkg::uart_bit_t'(adc_pkg::UART_BITS - 1);
                end
            end else if (baud_cnt != '0) begin
                baud_cnt <= baud_cnt - 1'b1;
            end else if (bits_left == '0) begin
                busy <= 1'b0;                   // Stop bit has run its full time.
            end else begin
                frame_q   <= {1'b1, frame_q[adc_pkg::UART_BITS-1:1]};
                bits_left <= bits_left - 1'b1;
                baud_cnt  <= adc_pkg::baud_cnt_t'(adc_pkg::BAUD_DIV - 1);
            end
        end
    end

endmodule
